/* verilog.f */
+incdir+common
+incdir+test
common/sa_data_pkg.sv
common/sa_geom_pkg.sv
systolic/systolic_cell.sv
systolic/band_matmul_array.sv
test/tb_band_matmul.sv

/* run_sim.sh */
#!/bin/sh
# Build the band matmul testbench with Verilator, run it, and decide
# pass or fail from the simulation log.

cd "$(dirname "$0")" || exit 1

TOP=tb_band_matmul
BUILD_LOG=build.log
SIM_LOG=sim.log

rm -f "$BUILD_LOG" "$SIM_LOG"

verilator --binary --timing --assert -j 0 \
    -f verilog.f \
    --top-module "$TOP" \
    -o "$TOP" > "$BUILD_LOG" 2>&1 \
    || { cat "$BUILD_LOG"; echo "build failed"; exit 1; }

./obj_dir/"$TOP" > "$SIM_LOG" 2>&1
cat "$SIM_LOG"

grep -q "^All tests passed$" "$SIM_LOG" \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL"; exit 1; }

/* test/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

////////////////////
// random source
////////////////////

logic [31:0] lfsr_state = LFSR_SEED;

// galois form, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// one lfsr step per bit taken, lsb first into the word
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        bits = {bits[30:0], lfsr_state[0]};
    end
    return bits;
endfunction

////////////////////
// reference model
////////////////////

// register contents of every cell after the latest edge
sa_data_pkg::elem_t model_a [`ARRAY_SIZE][`ARRAY_SIZE][`NUM_LANES];
sa_data_pkg::elem_t model_b [`ARRAY_SIZE][`ARRAY_SIZE][`NUM_LANES];
sa_data_pkg::elem_t model_c [`ARRAY_SIZE][`ARRAY_SIZE][`NUM_LANES];

function automatic bit cell_in_band(input int row, input int col);
    return (col - row < `MATRIX_SIZE) && (row - col < `MATRIX_SIZE);
endfunction

// advance all cells by one clock edge
task automatic model_step();
    sa_data_pkg::elem_t next_a [`ARRAY_SIZE][`ARRAY_SIZE][`NUM_LANES];
    sa_data_pkg::elem_t next_b [`ARRAY_SIZE][`ARRAY_SIZE][`NUM_LANES];
    sa_data_pkg::elem_t next_c [`ARRAY_SIZE][`ARRAY_SIZE][`NUM_LANES];
    sa_data_pkg::elem_t a_src;
    sa_data_pkg::elem_t b_src;
    sa_data_pkg::elem_t c_src;
    for (int r = 0; r < `ARRAY_SIZE; r++) begin
        for (int c = 0; c < `ARRAY_SIZE; c++) begin
            for (int l = 0; l < `NUM_LANES; l++) begin
                if (c == 0) a_src = left_in[r][l];
                else        a_src = model_a[r][c-1][l];
                if (r == 0) b_src = top_in[c][l];
                else        b_src = model_b[r-1][c][l];
                if (r == 0 || c == 0) c_src = '0;   // boundary sums enter empty
                else                  c_src = model_c[r-1][c-1][l];
                if (!rst_n) begin
                    next_a[r][c][l] = '0;
                    next_b[r][c][l] = '0;
                    next_c[r][c][l] = '0;
                end else begin
                    next_a[r][c][l] = a_src;
                    next_b[r][c][l] = b_src;
                    if (cell_in_band(r, c)) next_c[r][c][l] = c_src + a_src * b_src;
                    else                    next_c[r][c][l] = '0;
                end
            end
        end
    end
    model_a = next_a;
    model_b = next_b;
    model_c = next_c;
endtask

// diagonal k ends on the bottom row or on the right column
function automatic sa_data_pkg::elem_t expected_sum(input int k, input int lane);
    int offset;
    int row;
    int col;
    offset = k - (`MATRIX_SIZE - 1);
    if (offset <= 0) begin
        row = `ARRAY_SIZE - 1;
        col = `ARRAY_SIZE - 1 + offset;
    end else begin
        row = `ARRAY_SIZE - 1 - offset;
        col = `ARRAY_SIZE - 1;
    end
    return model_c[row][col][lane];
endfunction

////////////////////
// checking
////////////////////

task automatic check_value(input string sig, input int diag, input int lane,
                           input sa_data_pkg::elem_t got, input sa_data_pkg::elem_t exp);
    if (got !== exp) begin
        $display("mismatch %s[%0d] lane %0d: got %h, expected %h", sig, diag, lane, got, exp);
        $display("Some tests failed");
        $fatal(1, "stopped at first error");
    end
endtask

`endif

/* test/tb_band_matmul.sv */
`timescale 1ns/100ps
`include "systolic_settings.svh"

module tb_band_matmul;

    localparam int          CLK_PERIOD_NS     = 20;
    localparam int          RESET_CYCLES      = 8;
    localparam int          IDLE_CYCLES       = 10;
    localparam int          RANDOM_CYCLES     = 400;
    localparam int          MATRIX_ROUNDS     = 3;
    localparam int          ROUND_CYCLES      = 16;    // 5 feed cycles, the rest flushes
    localparam int          WRAP_CYCLES       = 150;
    localparam int          PRE_RESET_CYCLES  = 60;
    localparam int          MID_RESET_CYCLES  = 4;
    localparam int          POST_RESET_CYCLES = 100;
    localparam int          DRAIN_CYCLES      = 12;
    localparam int          QUIET_LANE_A      = 2;
    localparam int          QUIET_LANE_B      = 5;
    localparam logic [31:0] LFSR_SEED         = 32'h9a81_dbb2;

    localparam int TOTAL_CYCLES = RESET_CYCLES + IDLE_CYCLES + RANDOM_CYCLES + DRAIN_CYCLES
                                + MATRIX_ROUNDS * ROUND_CYCLES + WRAP_CYCLES
                                + PRE_RESET_CYCLES + MID_RESET_CYCLES + 1
                                + POST_RESET_CYCLES + DRAIN_CYCLES;
    localparam int TIMEOUT_NS   = (TOTAL_CYCLES + 100) * CLK_PERIOD_NS;

    logic                   clk;
    logic                   rst_n;
    logic                   check_en;
    sa_data_pkg::lane_vec_t left_in  [`ARRAY_SIZE];
    sa_data_pkg::lane_vec_t top_in   [`ARRAY_SIZE];
    sa_data_pkg::lane_vec_t diag_sum [`ARRAY_SIZE];

    // per lane operand matrices for the skewed feed
    sa_data_pkg::elem_t mat_a [`NUM_LANES][`MATRIX_SIZE][`MATRIX_SIZE];
    sa_data_pkg::elem_t mat_b [`NUM_LANES][`MATRIX_SIZE][`MATRIX_SIZE];

    `include "tb_ref_model.svh"

    band_matmul_array dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .left_in  (left_in),
        .top_in   (top_in),
        .diag_sum (diag_sum)
    );

    ////////////////////
    // stimulus helpers
    ////////////////////

    task automatic clear_inputs();
        for (int i = 0; i < `ARRAY_SIZE; i++) begin
            left_in[i] = '0;
            top_in[i]  = '0;
        end
    endtask

    // near_max keeps every word within 16 of 16'hffff
    task automatic drive_random(input bit near_max);
        logic [31:0] bits;
        for (int i = 0; i < `ARRAY_SIZE; i++) begin
            for (int l = 0; l < `NUM_LANES; l++) begin
                bits = rand_bits(near_max ? 4 : `DATA_WIDTH);
                left_in[i][l] = near_max ? ~bits[`DATA_WIDTH-1:0] : bits[`DATA_WIDTH-1:0];
                bits = rand_bits(near_max ? 4 : `DATA_WIDTH);
                top_in[i][l] = near_max ? ~bits[`DATA_WIDTH-1:0] : bits[`DATA_WIDTH-1:0];
            end
        end
    endtask

    task automatic load_matrices();
        logic [31:0] bits;
        for (int l = 0; l < `NUM_LANES; l++) begin
            for (int i = 0; i < `MATRIX_SIZE; i++) begin
                for (int j = 0; j < `MATRIX_SIZE; j++) begin
                    bits = rand_bits(2 * `DATA_WIDTH);
                    if (l == QUIET_LANE_A || l == QUIET_LANE_B) bits = '0;   // idle lanes
                    mat_a[l][i][j] = bits[`DATA_WIDTH-1:0];
                    mat_b[l][i][j] = bits[2*`DATA_WIDTH-1:`DATA_WIDTH];
                end
            end
        end
    endtask

    // row r of a enters r cycles late, column c of b enters c cycles late
    task automatic drive_skewed(input int t);
        int idx;
        for (int i = 0; i < `ARRAY_SIZE; i++) begin
            idx = t - i;
            for (int l = 0; l < `NUM_LANES; l++) begin
                if (i < `MATRIX_SIZE && idx >= 0 && idx < `MATRIX_SIZE) begin
                    left_in[i][l] = mat_a[l][i][idx];
                    top_in[i][l]  = mat_b[l][idx][i];
                end else begin
                    left_in[i][l] = '0;
                    top_in[i][l]  = '0;
                end
            end
        end
    endtask

    task automatic check_all_zero();
        for (int k = 0; k < `ARRAY_SIZE; k++) begin
            for (int l = 0; l < `NUM_LANES; l++) begin
                check_value("diag_sum", k, l, diag_sum[k][l], '0);
            end
        end
    endtask

    task automatic check_quiet_lanes();
        for (int k = 0; k < `ARRAY_SIZE; k++) begin
            check_value("diag_sum", k, QUIET_LANE_A, diag_sum[k][QUIET_LANE_A], '0);
            check_value("diag_sum", k, QUIET_LANE_B, diag_sum[k][QUIET_LANE_B], '0);
        end
    endtask

    ////////////////////
    // clock, model, compare
    ////////////////////

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clk = ~clk;
    end

    always @(posedge clk) model_step();

    // outputs are settled mid cycle
    always @(negedge clk) begin
        if (check_en) begin
            for (int k = 0; k < `ARRAY_SIZE; k++) begin
                for (int l = 0; l < `NUM_LANES; l++) begin
                    check_value("diag_sum", k, l, diag_sum[k][l], expected_sum(k, l));
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("simulation timed out");
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

    ////////////////////
    // test sequence
    ////////////////////

    initial begin
        rst_n    = 1'b0;
        check_en = 1'b0;
        clear_inputs();
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n    = 1'b1;
        check_en = 1'b1;

        // idle array reads zero
        repeat (IDLE_CYCLES) begin
            @(posedge clk);
            #2;
            check_all_zero();
        end

        repeat (RANDOM_CYCLES) begin
            @(posedge clk);
            #2 drive_random(1'b0);
        end

        // empty the pipeline so the idle lanes start at zero
        clear_inputs();
        repeat (DRAIN_CYCLES) @(posedge clk);

        // matrices in skewed order, two lanes left idle
        for (int round = 0; round < MATRIX_ROUNDS; round++) begin
            load_matrices();
            for (int t = 0; t < ROUND_CYCLES; t++) begin
                @(posedge clk);
                #2;
                check_quiet_lanes();
                drive_skewed(t);
            end
        end

        repeat (WRAP_CYCLES) begin
            @(posedge clk);
            #2 drive_random(1'b1);   // products wrap mod 2^16
        end

        repeat (PRE_RESET_CYCLES) begin
            @(posedge clk);
            #2 drive_random(1'b0);
        end
        @(posedge clk);
        #2;
        rst_n = 1'b0;
        drive_random(1'b0);
        for (int i = 0; i < MID_RESET_CYCLES; i++) begin
            @(posedge clk);
            #2;
            if (i == 0) check_all_zero();   // first reset edge seen
            if (i == MID_RESET_CYCLES - 1) rst_n = 1'b1;
            drive_random(1'b0);
        end
        repeat (POST_RESET_CYCLES) begin
            @(posedge clk);
            #2 drive_random(1'b0);
        end

        clear_inputs();
        repeat (DRAIN_CYCLES) @(posedge clk);
        @(negedge clk);
        #1;
        $display("All tests passed");
        $finish;
    end

endmodule

/* systolic/band_matmul_array.sv */
`timescale 1ns/100ps
`include "systolic_settings.svh"

module band_matmul_array (
    input  logic                   clk,
    input  logic                   rst_n,
    input  sa_data_pkg::lane_vec_t left_in  [`ARRAY_SIZE],   // a operand, one per row
    input  sa_data_pkg::lane_vec_t top_in   [`ARRAY_SIZE],   // b operand, one per column
    output sa_data_pkg::lane_vec_t diag_sum [`ARRAY_SIZE]    // one result per band diagonal
);

    ////////////////////
    // grid nets
    ////////////////////

    // a_net[r][c] / b_net[r][c] are the operand inputs of cell (r,c)
    sa_data_pkg::lane_vec_t a_net [`ARRAY_SIZE][`ARRAY_SIZE];
    sa_data_pkg::lane_vec_t b_net [`ARRAY_SIZE][`ARRAY_SIZE];

    // c_net[r][c] is the sum input of cell (r,c)
    // the extra row and column hold the sums leaving the bottom and right edges
    sa_data_pkg::lane_vec_t c_net [`ARRAY_SIZE+1][`ARRAY_SIZE+1];

    ////////////////////
    // boundaries
    ////////////////////

    for (genvar gi = 0; gi < `ARRAY_SIZE; gi++) begin : g_edge_in
        assign a_net[gi][0] = left_in[gi];   // row gi enters at column 0
        assign b_net[0][gi] = top_in[gi];    // column gi enters at row 0
    end

    // sums start empty along the top row and the left column
    for (genvar gj = 0; gj < `ARRAY_SIZE; gj++) begin : g_zero_top
        assign c_net[0][gj] = sa_data_pkg::lane_zero;
    end

    for (genvar gj = 1; gj < `ARRAY_SIZE; gj++) begin : g_zero_left
        assign c_net[gj][0] = sa_data_pkg::lane_zero;
    end

    ////////////////////
    // cell grid
    ////////////////////

    for (genvar gr = 0; gr < `ARRAY_SIZE; gr++) begin : g_row
        for (genvar gc = 0; gc < `ARRAY_SIZE; gc++) begin : g_col

            localparam sa_geom_pkg::grid_idx_t row_idx = sa_geom_pkg::grid_idx_t'(gr);
            localparam sa_geom_pkg::grid_idx_t col_idx = sa_geom_pkg::grid_idx_t'(gc);
            localparam bit is_mac = sa_geom_pkg::in_band(row_idx, col_idx);

            if ((gr < `ARRAY_SIZE - 1) && (gc < `ARRAY_SIZE - 1)) begin : g_inner
                // feeds right, down and diagonally
                systolic_cell #(
                    .has_mac (is_mac)
                ) u_cell (
                    .clk   (clk),
                    .rst_n (rst_n),
                    .a_in  (a_net[gr][gc]),
                    .b_in  (b_net[gr][gc]),
                    .c_in  (c_net[gr][gc]),
                    .a_out (a_net[gr][gc+1]),
                    .b_out (b_net[gr+1][gc]),
                    .c_out (c_net[gr+1][gc+1])
                );
            end else if (gr < `ARRAY_SIZE - 1) begin : g_right
                // a stops at the right edge
                systolic_cell #(
                    .has_mac (is_mac)
                ) u_cell (
                    .clk   (clk),
                    .rst_n (rst_n),
                    .a_in  (a_net[gr][gc]),
                    .b_in  (b_net[gr][gc]),
                    .c_in  (c_net[gr][gc]),
                    .a_out (),
                    .b_out (b_net[gr+1][gc]),
                    .c_out (c_net[gr+1][gc+1])
                );
            end else if (gc < `ARRAY_SIZE - 1) begin : g_bottom
                // b stops at the bottom edge
                systolic_cell #(
                    .has_mac (is_mac)
                ) u_cell (
                    .clk   (clk),
                    .rst_n (rst_n),
                    .a_in  (a_net[gr][gc]),
                    .b_in  (b_net[gr][gc]),
                    .c_in  (c_net[gr][gc]),
                    .a_out (a_net[gr][gc+1]),
                    .b_out (),
                    .c_out (c_net[gr+1][gc+1])
                );
            end else begin : g_corner
                // bottom right, only the main diagonal sum leaves
                systolic_cell #(
                    .has_mac (is_mac)
                ) u_cell (
                    .clk   (clk),
                    .rst_n (rst_n),
                    .a_in  (a_net[gr][gc]),
                    .b_in  (b_net[gr][gc]),
                    .c_in  (c_net[gr][gc]),
                    .a_out (),
                    .b_out (),
                    .c_out (c_net[gr+1][gc+1])
                );
            end

        end
    end

    ////////////////////
    // diagonal results
    ////////////////////

    // diagonal k ends on the bottom row for offsets <= 0, else on the right column
    for (genvar gk = 0; gk < `ARRAY_SIZE; gk++) begin : g_diag

        localparam sa_geom_pkg::diag_idx_t diag_idx = sa_geom_pkg::diag_idx_t'(gk);
        localparam int last_row = int'(sa_geom_pkg::end_row(diag_idx));
        localparam int last_col = int'(sa_geom_pkg::end_col(diag_idx));

        assign diag_sum[gk] = c_net[last_row+1][last_col+1];   // registered c of last cell

        // the end cell must be a band cell, so reset reaches the result port
        a_diag_rst : assert property (
            @(posedge clk) !rst_n |=> (diag_sum[gk] == '0)
        ) else $error("diag_sum[%0d] not cleared after reset", gk);

    end

endmodule

/* systolic/systolic_cell.sv */
`timescale 1ns/100ps
`include "systolic_settings.svh"

module systolic_cell #(
    parameter bit has_mac = 1'b1   // 0 gives a plain delay cell
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  sa_data_pkg::lane_vec_t a_in,    // from the left neighbour
    input  sa_data_pkg::lane_vec_t b_in,    // from the cell above
    input  sa_data_pkg::lane_vec_t c_in,    // partial sum, up-left neighbour
    output sa_data_pkg::lane_vec_t a_out,
    output sa_data_pkg::lane_vec_t b_out,
    output sa_data_pkg::lane_vec_t c_out
);

    ////////////////////
    // operand pipeline
    ////////////////////

    // a moves right, b moves down, one hop per clock
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a_out <= '0;
            b_out <= '0;
        end else begin
            a_out <= a_in;
            b_out <= b_in;
        end
    end

    ////////////////////
    // partial sum
    ////////////////////

    if (has_mac) begin : g_mac

        sa_data_pkg::lane_vec_t c_next;

        // lanes never interact, each one wraps mod 2^16 on its own
        always_comb begin
            for (int lane = 0; lane < `NUM_LANES; lane++) begin
                c_next[lane] = c_in[lane] + a_in[lane] * b_in[lane];   // unsigned
            end
        end

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                c_out <= '0;
            end else begin
                c_out <= c_next;
            end
        end

    end else begin : g_delay

        // off the band, no sum passes through here
        assign c_out = sa_data_pkg::lane_zero;

        // a delay cell only retimes the operand by one clock
        a_delay_pass : assert property (
            @(posedge clk) rst_n |=> (a_out == $past(a_in))
        ) else $error("delay cell lost its a operand");

    end

    ////////////////////
    // checks
    ////////////////////

    // reset leaves every register of the cell empty on the next cycle
    a_rst_clear : assert property (
        @(posedge clk) !rst_n |=> (a_out == '0) && (b_out == '0) && (c_out == '0)
    ) else $error("cell outputs not cleared by reset");

endmodule

/* common/sa_geom_pkg.sv */
`include "systolic_settings.svh"

package sa_geom_pkg;

    ////////////////////
    // grid indices
    ////////////////////

    typedef logic [$clog2(`ARRAY_SIZE)-1:0] grid_idx_t;   // row or column
    typedef logic [$clog2(`ARRAY_SIZE)-1:0] diag_idx_t;   // band diagonal number

    // cell belongs to the band when |col - row| < MATRIX_SIZE
    function automatic bit in_band(grid_idx_t row, grid_idx_t col);
        int diff;
        diff = int'(col) - int'(row);
        return (diff < `MATRIX_SIZE) && (diff > -`MATRIX_SIZE);
    endfunction

    // offset col - row of diagonal k
    function automatic int diag_offset(diag_idx_t k);
        return int'(k) - (`MATRIX_SIZE - 1);
    endfunction

    // last cell of diagonal k, bottom row for offset <= 0, else right column
    function automatic grid_idx_t end_row(diag_idx_t k);
        int offset;
        offset = diag_offset(k);
        if (offset <= 0) begin
            return grid_idx_t'(`ARRAY_SIZE - 1);
        end
        return grid_idx_t'(`ARRAY_SIZE - 1 - offset);
    endfunction

    function automatic grid_idx_t end_col(diag_idx_t k);
        int offset;
        offset = diag_offset(k);
        if (offset <= 0) begin
            return grid_idx_t'(`ARRAY_SIZE - 1 + offset);
        end
        return grid_idx_t'(`ARRAY_SIZE - 1);
    endfunction

endpackage

/* common/sa_data_pkg.sv */
`include "systolic_settings.svh"

package sa_data_pkg;

    ////////////////////
    // data words
    ////////////////////

    // a single lane word, arithmetic wraps at this width
    typedef logic [`DATA_WIDTH-1:0] elem_t;

    // all lanes of one operand side by side
    // lane 0 sits in the low bits
    typedef elem_t [`NUM_LANES-1:0] lane_vec_t;

    // empty partial sum
    localparam lane_vec_t lane_zero = '0;

endpackage

/* common/systolic_settings.svh */
`ifndef SYSTOLIC_SETTINGS_SVH
`define SYSTOLIC_SETTINGS_SVH

////////////////////
// array geometry
////////////////////

// order of the square operand matrices
`define MATRIX_SIZE 3

// grid side, one row/column per band diagonal
`define ARRAY_SIZE (2 * `MATRIX_SIZE - 1)

////////////////////
// datapath
////////////////////

`define DATA_WIDTH 16   // one lane word
`define NUM_LANES  8    // independent lanes per operand

`endif
